// File: src/isa_pkg.sv
package isa_pkg;

    // --------------------------------------------------
    // instruction format
    // --------------------------------------------------

    // 2-bit op, 2-bit rs1, 2-bit rs2, 2-bit rd
    localparam int INST_W    = 8;
    localparam int OP_W      = 2;
    localparam int REG_IDX_W = 2;

    // field offsets inside the instruction word
    localparam int OP_LSB  = 6;
    localparam int RS1_LSB = 4;
    localparam int RS2_LSB = 2;
    localparam int RD_LSB  = 0;

    // architectural registers, one per index value
    localparam int NUM_REGS = 1 << REG_IDX_W;

    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------

    typedef enum logic [OP_W-1:0] {
        OP_NOP = 2'b00,
        OP_ADD = 2'b01,
        OP_SUB = 2'b10,
        OP_AND = 2'b11
    } opcode_e;

endpackage

// File: src/core_pkg.sv
package core_pkg;

    // datapath width
    localparam int WORD_W = 8;

    typedef logic [WORD_W-1:0] word_t;

    // where an operand is taken from in ID
    typedef enum logic [1:0] {
        FWD_RF = 2'b00,
        FWD_WB = 2'b01,
        FWD_EX = 2'b10
    } fwd_src_e;

    // scoreboard entry bit positions
    localparam int WR_EX_BIT = 1;
    localparam int WR_WB_BIT = 0;

    // per-register pending write, EX bit above WB bit
    typedef logic [1:0] wr_stage_t;

endpackage

// File: src/pipe_scoreboard.sv
`timescale 1ns/1ps

module pipe_scoreboard (
    input  logic                clk,
    input  logic                rst,
    input  logic                id_wen,
    input  isa_pkg::reg_idx_t   id_rd,
    input  isa_pkg::reg_idx_t   rs1,
    input  isa_pkg::reg_idx_t   rs2,
    output core_pkg::fwd_src_e  rs1_src,
    output core_pkg::fwd_src_e  rs2_src
);

    // one entry per architectural register
    core_pkg::wr_stage_t entries [isa_pkg::NUM_REGS];

    // newest write wins, so EX beats WB
    function automatic core_pkg::fwd_src_e stage_to_src(input core_pkg::wr_stage_t stage);
        core_pkg::fwd_src_e src;
        if (stage[core_pkg::WR_EX_BIT]) begin
            src = core_pkg::FWD_EX;
        end else if (stage[core_pkg::WR_WB_BIT]) begin
            src = core_pkg::FWD_WB;
        end else begin
            src = core_pkg::FWD_RF;
        end
        return src;
    endfunction

    // --------------------------------------------------
    // entry update
    // --------------------------------------------------

    // each entry moves one stage per cycle; an issued write enters at EX
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                entries[i][core_pkg::WR_EX_BIT] <=
                    id_wen && (id_rd == isa_pkg::reg_idx_t'(i));
                entries[i][core_pkg::WR_WB_BIT] <= entries[i][core_pkg::WR_EX_BIT];
            end
        end
    end

    // --------------------------------------------------
    // operand lookup
    // --------------------------------------------------

    // rs1 and rs2 each use their own entry
    always_comb begin
        rs1_src = stage_to_src(entries[rs1]);
        rs2_src = stage_to_src(entries[rs2]);
    end

endmodule

// File: src/pipe_regfile.sv
`timescale 1ns/1ps

module pipe_regfile (
    input  logic               clk,
    input  logic               rst,

    // operand reads for ID
    input  isa_pkg::reg_idx_t  rs1,
    input  isa_pkg::reg_idx_t  rs2,
    output core_pkg::word_t    rs1_rf,
    output core_pkg::word_t    rs2_rf,

    // writeback from EX/WB
    input  logic               wb_en,
    input  isa_pkg::reg_idx_t  wb_rd,
    input  core_pkg::word_t    wb_data,

    // host preload
    input  logic               load_en,
    input  isa_pkg::reg_idx_t  load_addr,
    input  core_pkg::word_t    load_data,

    // host debug read
    input  isa_pkg::reg_idx_t  dbg_addr,
    output core_pkg::word_t    dbg_data
);

    core_pkg::word_t regs [isa_pkg::NUM_REGS];

    // --------------------------------------------------
    // write ports
    // --------------------------------------------------

    // writeback wins over a load to the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                if (wb_en && (wb_rd == isa_pkg::reg_idx_t'(i))) begin
                    regs[i] <= wb_data;
                end else if (load_en && (load_addr == isa_pkg::reg_idx_t'(i))) begin
                    regs[i] <= load_data;
                end
            end
        end
    end

    // plain reads, no bypass here
    assign rs1_rf   = regs[rs1];
    assign rs2_rf   = regs[rs2];
    assign dbg_data = regs[dbg_addr];

endmodule

// File: src/pipe_decode.sv
`timescale 1ns/1ps

module pipe_decode (
    input  logic                clk,
    input  logic                rst,
    input  isa_pkg::inst_t      inst,

    // issue info for the scoreboard
    output logic                id_wen,
    output isa_pkg::reg_idx_t   id_rd,

    // operand indices for scoreboard and register file
    output isa_pkg::reg_idx_t   rs1,
    output isa_pkg::reg_idx_t   rs2,

    // operand sources
    input  core_pkg::fwd_src_e  rs1_src,
    input  core_pkg::fwd_src_e  rs2_src,
    input  core_pkg::word_t     rs1_rf,
    input  core_pkg::word_t     rs2_rf,
    input  core_pkg::word_t     ex_result,
    input  core_pkg::word_t     wb_data,

    // ID/EX register
    output isa_pkg::opcode_e    ex_op,
    output logic                ex_wen,
    output isa_pkg::reg_idx_t   ex_rd,
    output core_pkg::word_t     ex_a,
    output core_pkg::word_t     ex_b
);

    isa_pkg::opcode_e id_op;
    core_pkg::word_t  id_a;
    core_pkg::word_t  id_b;

    // --------------------------------------------------
    // field decode
    // --------------------------------------------------

    assign id_op = isa_pkg::opcode_e'(inst[isa_pkg::OP_LSB +: isa_pkg::OP_W]);
    assign rs1   = inst[isa_pkg::RS1_LSB +: isa_pkg::REG_IDX_W];
    assign rs2   = inst[isa_pkg::RS2_LSB +: isa_pkg::REG_IDX_W];
    assign id_rd = inst[isa_pkg::RD_LSB +: isa_pkg::REG_IDX_W];

    // every opcode but NOP writes rd
    assign id_wen = (id_op != isa_pkg::OP_NOP);

    // --------------------------------------------------
    // operand forwarding
    // --------------------------------------------------

    // each operand follows its own source
    always_comb begin
        case (rs1_src)
            core_pkg::FWD_EX: id_a = ex_result;
            core_pkg::FWD_WB: id_a = wb_data;
            default:          id_a = rs1_rf;
        endcase
    end

    always_comb begin
        case (rs2_src)
            core_pkg::FWD_EX: id_b = ex_result;
            core_pkg::FWD_WB: id_b = wb_data;
            default:          id_b = rs2_rf;
        endcase
    end

    // --------------------------------------------------
    // ID/EX register
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wen <= 1'b0;
        end else begin
            ex_wen <= id_wen;
        end
    end

    // payload follows ex_wen
    always_ff @(posedge clk) begin
        ex_op <= id_op;
        ex_rd <= id_rd;
        ex_a  <= id_a;
        ex_b  <= id_b;
    end

endmodule

// File: src/pipe_execute.sv
`timescale 1ns/1ps

module pipe_execute (
    input  logic               clk,
    input  logic               rst,

    // from ID/EX
    input  isa_pkg::opcode_e   ex_op,
    input  logic               ex_wen,
    input  isa_pkg::reg_idx_t  ex_rd,
    input  core_pkg::word_t    ex_a,
    input  core_pkg::word_t    ex_b,

    // live ALU result, forwarded to ID
    output core_pkg::word_t    ex_result,

    // EX/WB register, drives writeback and the WB forward path
    output logic               wb_en,
    output isa_pkg::reg_idx_t  wb_rd,
    output core_pkg::word_t    wb_data
);

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------

    // add and sub wrap modulo 256
    always_comb begin
        case (ex_op)
            isa_pkg::OP_ADD: begin
                ex_result = ex_a + ex_b;
            end
            isa_pkg::OP_SUB: begin
                ex_result = ex_a - ex_b;
            end
            isa_pkg::OP_AND: begin
                ex_result = ex_a & ex_b;
            end
            default: begin
                // nop has no result
                ex_result = '0;
            end
        endcase
    end

    // --------------------------------------------------
    // EX/WB register
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

// File: src/pipe_core.sv
`timescale 1ns/1ps

module pipe_core (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::inst_t     inst,

    // host preload
    input  logic               load_en,
    input  isa_pkg::reg_idx_t  load_addr,
    input  core_pkg::word_t    load_data,

    // host debug read
    input  isa_pkg::reg_idx_t  dbg_addr,
    output core_pkg::word_t    dbg_data
);

    // --------------------------------------------------
    // stage wiring
    // --------------------------------------------------

    // ID to scoreboard and register file
    logic                id_wen;
    isa_pkg::reg_idx_t   id_rd;
    isa_pkg::reg_idx_t   rs1;
    isa_pkg::reg_idx_t   rs2;

    // back into ID
    core_pkg::fwd_src_e  rs1_src;
    core_pkg::fwd_src_e  rs2_src;
    core_pkg::word_t     rs1_rf;
    core_pkg::word_t     rs2_rf;

    // ID/EX
    isa_pkg::opcode_e    ex_op;
    logic                ex_wen;
    isa_pkg::reg_idx_t   ex_rd;
    core_pkg::word_t     ex_a;
    core_pkg::word_t     ex_b;
    core_pkg::word_t     ex_result;

    // EX/WB
    logic                wb_en;
    isa_pkg::reg_idx_t   wb_rd;
    core_pkg::word_t     wb_data;

    pipe_decode i_decode (
        .clk, .rst, .inst,
        .id_wen, .id_rd, .rs1, .rs2,
        .rs1_src, .rs2_src, .rs1_rf, .rs2_rf, .ex_result, .wb_data,
        .ex_op, .ex_wen, .ex_rd, .ex_a, .ex_b
    );

    pipe_scoreboard i_scoreboard (
        .clk, .rst, .id_wen, .id_rd, .rs1, .rs2, .rs1_src, .rs2_src
    );

    pipe_execute i_execute (
        .clk, .rst, .ex_op, .ex_wen, .ex_rd, .ex_a, .ex_b,
        .ex_result, .wb_en, .wb_rd, .wb_data
    );

    pipe_regfile i_regfile (
        .clk, .rst, .rs1, .rs2, .rs1_rf, .rs2_rf,
        .wb_en, .wb_rd, .wb_data,
        .load_en, .load_addr, .load_data,
        .dbg_addr, .dbg_data
    );

endmodule

// File: dv/pipe_core_properties.sv
`timescale 1ns/1ps

module pipe_core_properties (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_en,
    input  logic                          ex_wen,
    input  logic                          wb_en,
    input  isa_pkg::reg_idx_t             wb_rd,
    input  logic [isa_pkg::NUM_REGS-1:0]  wb_pending
);

    // --------------------------------------------------
    // pipeline control
    // --------------------------------------------------

    // valid bits clear one cycle into reset
    a_reset_clears: assert property (@(posedge clk) rst |=> (!ex_wen && !wb_en))
        else $error("ex_wen or wb_en still set in the cycle after reset");

    // host loads only into a drained pipeline
    a_load_idle: assert property (@(posedge clk) disable iff (rst)
        load_en |-> (!ex_wen && !wb_en))
        else $error("host load while a pipeline write is pending");

    // WB bit of each entry tracks the EX/WB register
    for (genvar i = 0; i < isa_pkg::NUM_REGS; i++) begin : g_wb_track
        a_wb_match: assert property (@(posedge clk) disable iff (rst)
            wb_pending[i] |-> (wb_en && (wb_rd == isa_pkg::reg_idx_t'(i))))
            else $error("scoreboard entry %0d has a WB write the EX/WB register lacks", i);
    end

endmodule

bind pipe_core pipe_core_properties i_properties (
    .clk,
    .rst,
    .load_en,
    .ex_wen,
    .wb_en,
    .wb_rd,
    .wb_pending({
        i_scoreboard.entries[3][core_pkg::WR_WB_BIT],
        i_scoreboard.entries[2][core_pkg::WR_WB_BIT],
        i_scoreboard.entries[1][core_pkg::WR_WB_BIT],
        i_scoreboard.entries[0][core_pkg::WR_WB_BIT]
    })
);

// File: dv/pipe_core_tb.sv
`timescale 1ns/1ps

module pipe_core_tb;

    localparam int RAND_COUNT = 200;
    localparam int CLK_HALF   = 10;
    localparam int MARGIN_NS  = 2000;

    typedef enum {ROW_LOAD, ROW_INST, ROW_CHECK} row_kind_e;

    // load and check rows use addr and data, instruction rows use inst
    typedef struct {
        row_kind_e         kind;
        isa_pkg::inst_t    inst;
        isa_pkg::reg_idx_t addr;
        core_pkg::word_t   data;
    } row_t;

    logic              clk = 1'b0;
    logic              rst;
    isa_pkg::inst_t    inst;
    logic              load_en;
    isa_pkg::reg_idx_t load_addr;
    core_pkg::word_t   load_data;
    isa_pkg::reg_idx_t dbg_addr;
    core_pkg::word_t   dbg_data;

    row_t            rows[$];
    core_pkg::word_t model_regs [isa_pkg::NUM_REGS];
    bit              table_ready = 1'b0;
    int              num_rows;

    pipe_core i_dut (
        .clk, .rst, .inst, .load_en, .load_addr, .load_data, .dbg_addr, .dbg_data
    );

    always #(CLK_HALF) clk = ~clk;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    function automatic isa_pkg::inst_t make_inst(isa_pkg::opcode_e op,
        isa_pkg::reg_idx_t rs1, isa_pkg::reg_idx_t rs2, isa_pkg::reg_idx_t rd);
        return {op, rs1, rs2, rd};
    endfunction

    // 8-bit wrap on add and sub
    function automatic core_pkg::word_t alu_ref(isa_pkg::opcode_e op,
        core_pkg::word_t a, core_pkg::word_t b);
        case (op)
            isa_pkg::OP_ADD: return a + b;
            isa_pkg::OP_SUB: return a - b;
            isa_pkg::OP_AND: return a & b;
            default:         return '0;
        endcase
    endfunction

    // in-order execution at issue
    task automatic model_exec(isa_pkg::inst_t w);
        isa_pkg::opcode_e op;
        op = isa_pkg::opcode_e'(w[7:6]);
        if (op != isa_pkg::OP_NOP) begin
            model_regs[w[1:0]] = alu_ref(op, model_regs[w[5:4]], model_regs[w[3:2]]);
        end
    endtask

    // --------------------------------------------------
    // drive and check
    // --------------------------------------------------

    task automatic check_word(core_pkg::word_t got, core_pkg::word_t expected, string msg);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: %s, got %02h expected %02h",
                $time, msg, got, expected);
            $display("Some tests failed");
            $fatal(1, "register value check failed");
        end
    endtask

    task automatic issue(isa_pkg::inst_t w);
        @(negedge clk);
        inst    = w;
        load_en = 1'b0;
    endtask

    // two nops first so nothing is pending in EX or WB
    task automatic load_reg(isa_pkg::reg_idx_t addr, core_pkg::word_t value);
        issue('0);
        issue('0);
        @(negedge clk);
        inst      = '0;
        load_en   = 1'b1;
        load_addr = addr;
        load_data = value;
        model_regs[addr] = value;
    endtask

    // drain three cycles, then read mid low phase
    task automatic check_reg(isa_pkg::reg_idx_t addr, core_pkg::word_t expected, string msg);
        repeat (3) issue('0);
        @(negedge clk);
        inst     = '0;
        load_en  = 1'b0;
        dbg_addr = addr;
        #2;
        check_word(dbg_data, expected, msg);
    endtask

    // --------------------------------------------------
    // directed table
    // --------------------------------------------------

    task automatic push_row(row_kind_e kind, isa_pkg::inst_t w, int addr, int data);
        row_t r;
        r.kind = kind;
        r.inst = w;
        r.addr = isa_pkg::reg_idx_t'(addr);
        r.data = core_pkg::word_t'(data);
        rows.push_back(r);
    endtask

    task automatic push_inst(isa_pkg::opcode_e op, int rs1, int rs2, int rd);
        push_row(ROW_INST, make_inst(op, isa_pkg::reg_idx_t'(rs1),
            isa_pkg::reg_idx_t'(rs2), isa_pkg::reg_idx_t'(rd)), 0, 0);
    endtask

    task automatic build_table();
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            push_row(ROW_CHECK, '0, i, 8'h00);
        end
        // preload, then overwrite r1
        push_row(ROW_LOAD, '0, 0, 8'h10);
        push_row(ROW_LOAD, '0, 1, 8'h25);
        push_row(ROW_LOAD, '0, 2, 8'hf0);
        push_row(ROW_LOAD, '0, 3, 8'h0f);
        push_row(ROW_CHECK, '0, 1, 8'h25);
        push_row(ROW_LOAD, '0, 1, 8'h33);
        push_row(ROW_CHECK, '0, 1, 8'h33);
        push_row(ROW_CHECK, '0, 0, 8'h10);
        // isolated ops, sub and add both wrap
        push_inst(isa_pkg::OP_ADD, 0, 1, 3);
        push_row(ROW_CHECK, '0, 3, 8'h43);
        push_inst(isa_pkg::OP_SUB, 0, 1, 2);
        push_row(ROW_CHECK, '0, 2, 8'hdd);
        push_inst(isa_pkg::OP_ADD, 2, 2, 3);
        push_row(ROW_CHECK, '0, 3, 8'hba);
        push_inst(isa_pkg::OP_AND, 2, 3, 0);
        push_row(ROW_CHECK, '0, 0, 8'h98);
        push_inst(isa_pkg::OP_NOP, 1, 2, 3);
        push_row(ROW_CHECK, '0, 3, 8'hba);
        // back to back on rs1, then rs2, then both operands
        push_inst(isa_pkg::OP_ADD, 0, 1, 1);
        push_inst(isa_pkg::OP_SUB, 1, 3, 2);
        push_row(ROW_CHECK, '0, 2, 8'h11);
        push_row(ROW_CHECK, '0, 1, 8'hcb);
        push_inst(isa_pkg::OP_AND, 1, 2, 3);
        push_inst(isa_pkg::OP_ADD, 1, 3, 0);
        push_inst(isa_pkg::OP_ADD, 0, 0, 2);
        push_row(ROW_CHECK, '0, 0, 8'hcc);
        push_row(ROW_CHECK, '0, 2, 8'h98);
        // distance two, forwarded from WB
        push_inst(isa_pkg::OP_ADD, 0, 3, 1);
        push_inst(isa_pkg::OP_NOP, 0, 0, 0);
        push_inst(isa_pkg::OP_ADD, 1, 2, 3);
        push_row(ROW_CHECK, '0, 3, 8'h65);
        // two writes to r0, reader must see the newer one
        push_inst(isa_pkg::OP_ADD, 3, 3, 0);
        push_inst(isa_pkg::OP_AND, 1, 2, 0);
        push_inst(isa_pkg::OP_SUB, 0, 3, 2);
        push_row(ROW_CHECK, '0, 2, 8'h23);
        push_row(ROW_CHECK, '0, 0, 8'h88);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        isa_pkg::inst_t rand_inst;
        void'($urandom(1999));
        rst       = 1'b1;
        inst      = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        build_table();
        num_rows    = rows.size();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (rows[k]) begin
            case (rows[k].kind)
                ROW_LOAD: load_reg(rows[k].addr, rows[k].data);
                ROW_INST: begin
                    issue(rows[k].inst);
                    model_exec(rows[k].inst);
                end
                default: check_reg(rows[k].addr, rows[k].data,
                    $sformatf("table row %0d, r%0d", k, rows[k].addr));
            endcase
        end

        // random stream over all opcodes
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            load_reg(isa_pkg::reg_idx_t'(i), core_pkg::word_t'($urandom));
        end
        for (int i = 0; i < RAND_COUNT; i++) begin
            rand_inst = isa_pkg::inst_t'($urandom);
            issue(rand_inst);
            model_exec(rand_inst);
        end
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            check_reg(isa_pkg::reg_idx_t'(i), model_regs[i],
                $sformatf("r%0d after random stream", i));
        end

        $display("All tests passed");
        $finish;
    end

    // up to four cycles per row or random instruction
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (num_rows + RAND_COUNT) * 4 * 2 * CLK_HALF + MARGIN_NS;
        #(limit_ns);
        $display("the run timed out after %0d ns without finishing", limit_ns);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: pipe_core.f
src/isa_pkg.sv
src/core_pkg.sv
src/pipe_scoreboard.sv
src/pipe_regfile.sv
src/pipe_decode.sv
src/pipe_execute.sv
src/pipe_core.sv
dv/pipe_core_properties.sv
dv/pipe_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pipe_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module pipe_core_tb \
    -f pipe_core.f \
    -o sim_pipe_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_pipe_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
